//--- hdl/nes_loader_pkg.sv
////////////////////////////////////////////////////////////
// Shared constants, load state enum and bus structs
// for the cartridge input path
////////////////////////////////////////////////////////////

`default_nettype none

package nes_loader_pkg;

	////////////////////////////////////////////////////////////
	// Memory map and loader constants
	////////////////////////////////////////////////////////////

	localparam int ADDR_W = 22;
	localparam logic [ADDR_W-1:0] CHR_BASE = 22'h200000; // CHR sits above PRG space
	localparam int PRG_PAGE_SHIFT = 14;  // 16 KB PRG pages
	localparam int CHR_PAGE_SHIFT = 13;  // 8 KB CHR pages
	localparam int HEADER_BYTES = 16;
	localparam logic [7:0] CHEAT_INDEX = 8'hFF; // File type of a cheat file
	localparam int PAD_SHIFT_W = 24;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} load_state_e;

	////////////////////////////////////////////////////////////
	// Buses
	////////////////////////////////////////////////////////////

	// One byte write towards cartridge memory
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
		logic              write;
	} mem_wr_t;

	// Mapper configuration handed to the console core
	typedef struct packed {
		logic       has_saves;
		logic [3:0] prg_ram_shift;   // NES 2.0 only
		logic [7:0] submapper_byte;  // NES 2.0 only
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
		logic [1:0] spare;
	} mapper_flags_t;

	// Cheat code as seen by the core, all fields little endian in the file
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic a;
		logic b;
		logic select;
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_buttons_t;

endpackage

`default_nettype wire

//--- hdl/ines_header_decode.sv
////////////////////////////////////////////////////////////
// iNES header capture, magic and trainer check,
// NES 2.0 and dirty header handling, mapper flag decode
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ines_header_decode
	import nes_loader_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       load_start,
	input  wire logic       hdr_capture,
	input  wire logic       dl_wr,
	input  wire logic [7:0] dl_data,
	input  wire logic       invert_mirroring,
	output logic            hdr_ready,
	output logic            header_ok,
	output logic [7:0]      prg_pages,
	output logic [7:0]      chr_pages,
	output mapper_flags_t   flags
);

	localparam int CTR_W = $clog2(HEADER_BYTES);

	logic [7:0]       hdr [HEADER_BYTES];
	logic [CTR_W-1:0] ctr;
	logic [CTR_W-1:0] ctr_base;
	logic             capture;
	logic             is_nes20;
	logic             is_dirty;

	// Smallest k with pages <= 2^k, saturating at 7
	function automatic logic [2:0] size_class(input logic [7:0] pages);
		logic [2:0] k_min;
		k_min = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= (9'd1 << k))
				k_min = 3'(k);
		end
		return k_min;
	endfunction

	// A byte arriving together with load_start is header byte 0
	assign ctr_base = load_start ? '0 : ctr;
	assign capture  = (hdr_capture || load_start) && dl_wr;

	always_ff @(posedge clk) begin
		if (capture) begin
			hdr[ctr_base] <= dl_data;
			ctr           <= ctr_base + 1'b1;
		end else if (load_start) begin
			ctr <= '0;
		end
		hdr_ready <= capture && (ctr_base == CTR_W'(HEADER_BYTES - 1)); // After 16th byte
	end

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];

	// "NES" followed by EOF, trainers not supported
	assign header_ok = (hdr[0] == 8'h4E) && (hdr[1] == 8'h45) && (hdr[2] == 8'h53) &&
		(hdr[3] == 8'h1A) && !hdr[6][2];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumpers left junk in the tail of iNES 1.0 headers
	always_comb begin
		is_dirty = (hdr[9][7:1] != '0);
		for (int i = 10; i < HEADER_BYTES; i++)
			is_dirty = is_dirty || (hdr[i] != '0);
		is_dirty = is_dirty && !is_nes20;
	end

	always_comb begin
		flags                = '0;
		flags.has_saves      = hdr[6][1];
		flags.prg_ram_shift  = is_nes20 ? hdr[10][3:0] : 4'h0;
		flags.submapper_byte = is_nes20 ? hdr[8] : 8'h00;
		flags.four_screen    = hdr[6][3];
		flags.has_chr_ram    = (chr_pages == 8'h00);
		flags.mirroring      = hdr[6][0] ^ invert_mirroring;
		flags.chr_size       = size_class(chr_pages);
		flags.prg_size       = size_class(prg_pages);
		flags.mapper         = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	end

endmodule

`default_nettype wire

//--- hdl/rom_load_fsm.sv
////////////////////////////////////////////////////////////
// ROM load FSM with write address counter and
// remaining byte countdown for PRG and CHR
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rom_load_fsm
	import nes_loader_pkg::*;
#(
	parameter logic [ADDR_W-1:0] CHR_ADDR = CHR_BASE
)(
	input  wire logic       clk,
	input  wire logic       reset_nes,
	input  wire logic       load_start,
	input  wire logic       dl_active,
	input  wire logic       dl_wr,
	input  wire logic [7:0] dl_data,
	input  wire logic       hdr_ready,
	input  wire logic       header_ok,
	input  wire logic [7:0] prg_pages,
	input  wire logic [7:0] chr_pages,
	output logic            hdr_capture,
	output mem_wr_t         mem,
	output logic            busy,
	output logic            done,
	output logic            error
);

	load_state_e       state;
	logic [ADDR_W-1:0] addr;
	logic [ADDR_W-1:0] remain;  // Bytes left in current section
	logic              in_payload;
	logic              wr_en;

	assign in_payload  = (state == LOAD_PRG) || (state == LOAD_CHR);
	assign wr_en       = in_payload && (remain != '0) && dl_wr && !load_start;
	assign hdr_capture = (state == LOAD_HEADER);

	// Write goes out in the same cycle as the strobe
	always_comb begin
		mem.addr  = addr;
		mem.data  = dl_data;
		mem.write = wr_en;
	end

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes || load_start) begin
			state  <= LOAD_HEADER;
			addr   <= '0;
			remain <= '0;
			busy   <= 1'b0;
			done   <= 1'b0;
			error  <= 1'b0;
		end else begin
			case (state)
				LOAD_HEADER: begin
					if (hdr_ready) begin
						if (header_ok) begin
							state  <= LOAD_PRG;
							busy   <= 1'b1;
							addr   <= '0;  // PRG from address 0
							remain <= ADDR_W'(prg_pages) << PRG_PAGE_SHIFT;
						end else begin
							state <= LOAD_ERROR;
							done  <= 1'b1;
							error <= 1'b1;
						end
					end
				end
				LOAD_PRG, LOAD_CHR: begin
					if (remain != '0) begin
						if (wr_en) begin
							remain <= remain - 1'b1;
							addr   <= addr + 1'b1;
						end else if (!dl_active) begin
							// File ended short of the header's sizes
							state <= LOAD_ERROR;
							busy  <= 1'b0;
							done  <= 1'b1;
							error <= 1'b1;
						end
					end else if (state == LOAD_PRG) begin
						state  <= LOAD_CHR;
						addr   <= CHR_ADDR;
						remain <= ADDR_W'(chr_pages) << CHR_PAGE_SHIFT; // Zero means CHR RAM
					end else begin
						state <= LOAD_DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				end
				default: begin
					// Error and done hold until the next load_start
					state <= state;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/cheat_code_capture.sv
////////////////////////////////////////////////////////////
// Cheat record assembly into a 128-bit code word
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cheat_code_capture
	import nes_loader_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        reset_nes,
	input  wire logic        dl_active,
	input  wire logic [7:0]  dl_index,
	input  wire logic        dl_wr,
	input  wire logic [24:0] dl_addr,
	input  wire logic [7:0]  dl_data,
	output cheat_code_t      code,
	output logic             code_valid
);

	logic       cheat_wr;
	logic [1:0] field_sel;
	logic [1:0] byte_sel;

	assign cheat_wr  = dl_active && (dl_index == CHEAT_INDEX) && dl_wr;
	assign field_sel = dl_addr[3:2];  // Four bytes per field
	assign byte_sel  = dl_addr[1:0];  // Low byte first

	always_ff @(posedge clk) begin
		if (cheat_wr) begin
			case (field_sel)
				2'd0: code.flags[8*byte_sel +: 8]   <= dl_data;
				2'd1: code.address[8*byte_sel +: 8] <= dl_data;
				2'd2: code.compare[8*byte_sel +: 8] <= dl_data;
				default: code.replace[8*byte_sel +: 8] <= dl_data;
			endcase
		end
	end

	// Last byte of the record completes the code
	always_ff @(posedge clk) begin
		if (reset_nes)
			code_valid <= 1'b0;
		else
			code_valid <= cheat_wr && (dl_addr[3:0] == 4'hF);
	end

endmodule

`default_nettype wire

//--- hdl/joypad_serializer.sv
////////////////////////////////////////////////////////////
// Controller shift registers for both joypad ports,
// loaded by strobe, shifted on falling pad clock
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module joypad_serializer
	import nes_loader_pkg::*;
#(
	parameter int SHIFT_W = PAD_SHIFT_W
)(
	input  wire logic         clk,
	input  wire logic         reset_nes,
	input  wire logic         pad_strobe,
	input  wire logic [1:0]   pad_clock,
	input  wire pad_buttons_t joy_a,
	input  wire pad_buttons_t joy_b,
	input  wire logic         swap_joys,
	output logic [1:0]        pad_data
);

	pad_buttons_t pad_sel [2];
	logic [1:0]   clock_q;

	// Port assignment of the two controllers
	assign pad_sel[0] = swap_joys ? joy_b : joy_a;
	assign pad_sel[1] = swap_joys ? joy_a : joy_b;

	always_ff @(posedge clk) begin
		if (reset_nes)
			clock_q <= '0;
		else
			clock_q <= pad_clock;
	end

	////////////////////////////////////////////////////////////
	// One shift register per port
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 2; i++) begin : g_port
		logic [7:0]         serial_byte;
		logic [SHIFT_W-1:0] shift_q;
		logic               clock_fall;

		// A goes out first, Right last
		assign serial_byte = {pad_sel[i].right, pad_sel[i].left, pad_sel[i].down,
			pad_sel[i].up, pad_sel[i].start, pad_sel[i].select, pad_sel[i].b, pad_sel[i].a};
		assign clock_fall = clock_q[i] && !pad_clock[i];

		always_ff @(posedge clk) begin
			if (reset_nes) begin
				shift_q <= '0;
			end else if (pad_strobe) begin
				shift_q <= {{(SHIFT_W - 8){1'b1}}, serial_byte}; // No multitap, ones above
			end else if (clock_fall) begin
				shift_q <= {1'b0, shift_q[SHIFT_W-1:1]};
			end
		end

		assign pad_data[i] = shift_q[0];
	end

endmodule

`default_nettype wire

//--- hdl/nes_loader_top.sv
////////////////////////////////////////////////////////////
// Cartridge input path top level: download detection,
// download reset counter, mapper flag latch, instances
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module nes_loader_top
	import nes_loader_pkg::*;
#(
	parameter int DL_RESET_CYCLES = 255
)(
	input  wire logic         clk,
	input  wire logic         reset_nes,
	input  wire logic         dl_active,
	input  wire logic [7:0]   dl_index,
	input  wire logic         dl_wr,
	input  wire logic [24:0]  dl_addr,
	input  wire logic [7:0]   dl_data,
	input  wire logic         invert_mirroring,
	input  wire logic         pad_strobe,
	input  wire logic [1:0]   pad_clock,
	input  wire pad_buttons_t joy_a,
	input  wire pad_buttons_t joy_b,
	input  wire logic         swap_joys,
	output mem_wr_t           mem,
	output mapper_flags_t     mapper_flags,
	output logic              load_busy,
	output logic              load_done,
	output logic              load_error,
	output logic              machine_reset,
	output cheat_code_t       cheat_code,
	output logic              cheat_valid,
	output logic [1:0]        pad_data
);

	localparam int RST_CNT_W = $clog2(DL_RESET_CYCLES + 1);

	logic                 dl_active_q;
	logic                 game_active;
	logic                 load_start;
	logic                 game_wr;
	logic                 hdr_capture;
	logic                 hdr_ready;
	logic                 header_ok;
	logic [7:0]           prg_pages;
	logic [7:0]           chr_pages;
	mapper_flags_t        dec_flags;
	mapper_flags_t        flags_q;
	logic [RST_CNT_W-1:0] rst_cnt;

	////////////////////////////////////////////////////////////
	// Download detection
	////////////////////////////////////////////////////////////

	assign game_active = dl_active && (dl_index != CHEAT_INDEX);
	assign load_start  = game_active && !dl_active_q;  // First cycle of a game download
	assign game_wr     = dl_wr && game_active;         // Cheat bytes never reach the loader

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			dl_active_q <= 1'b0;
			rst_cnt     <= '0;
			flags_q     <= '0;
		end else begin
			dl_active_q <= dl_active;
			if (game_active)
				rst_cnt <= RST_CNT_W'(DL_RESET_CYCLES);
			else if (!load_busy && rst_cnt != '0)
				rst_cnt <= rst_cnt - 1'b1;  // Count only while loader idle
			if (load_done)
				flags_q <= dec_flags;
		end
	end

	assign machine_reset = game_active || (rst_cnt != '0);
	assign mapper_flags  = game_active ? '0 : flags_q;  // Hide stale flags mid download

	////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////

	ines_header_decode u_ines_header_decode (
		.clk              (clk),
		.load_start       (load_start),
		.hdr_capture      (hdr_capture),
		.dl_wr            (game_wr),
		.dl_data          (dl_data),
		.invert_mirroring (invert_mirroring),
		.hdr_ready        (hdr_ready),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (dec_flags)
	);

	rom_load_fsm #(
		.CHR_ADDR (CHR_BASE)
	) u_rom_load_fsm (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.load_start  (load_start),
		.dl_active   (dl_active),
		.dl_wr       (game_wr),
		.dl_data     (dl_data),
		.hdr_ready   (hdr_ready),
		.header_ok   (header_ok),
		.prg_pages   (prg_pages),
		.chr_pages   (chr_pages),
		.hdr_capture (hdr_capture),
		.mem         (mem),
		.busy        (load_busy),
		.done        (load_done),
		.error       (load_error)
	);

	cheat_code_capture u_cheat_code_capture (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.code       (cheat_code),
		.code_valid (cheat_valid)
	);

	joypad_serializer #(
		.SHIFT_W (PAD_SHIFT_W)
	) u_joypad_serializer (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.pad_strobe (pad_strobe),
		.pad_clock  (pad_clock),
		.joy_a      (joy_a),
		.joy_b      (joy_b),
		.swap_joys  (swap_joys),
		.pad_data   (pad_data)
	);

endmodule

`default_nettype wire

//--- dv/nes_loader_assert.sv
////////////////////////////////////////////////////////////
// Bound assertions on the loader top level
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module nes_loader_assert
	import nes_loader_pkg::*;
(
	input wire logic       clk,
	input wire logic       reset_nes,
	input wire logic       dl_active,
	input wire logic [7:0] dl_index,
	input wire mem_wr_t    mem,
	input wire logic       load_done,
	input wire logic       load_error,
	input wire logic       machine_reset,
	input wire logic       cheat_valid
);

	int unsigned assert_fails = 0;

	a_error_with_done: assert property (@(posedge clk) disable iff (reset_nes)
		load_error |-> load_done)
		else begin
			$error("load_error high while load_done low");
			assert_fails++;
		end

	a_cheat_pulse: assert property (@(posedge clk) disable iff (reset_nes)
		cheat_valid |=> !cheat_valid)
		else begin
			$error("cheat_valid longer than one cycle");
			assert_fails++;
		end

	// No writes after a failed load
	a_no_write_on_error: assert property (@(posedge clk) disable iff (reset_nes)
		!(mem.write && load_error))
		else begin
			$error("mem write while load_error high");
			assert_fails++;
		end

	// Held through the download and into the reset count
	a_reset_in_download: assert property (@(posedge clk) disable iff (reset_nes)
		(dl_active && dl_index != CHEAT_INDEX) |-> machine_reset ##1 machine_reset)
		else begin
			$error("machine_reset low during or right after game download");
			assert_fails++;
		end

endmodule

bind nes_loader_top nes_loader_assert u_nes_loader_assert (
	.clk           (clk),
	.reset_nes     (reset_nes),
	.dl_active     (dl_active),
	.dl_index      (dl_index),
	.mem           (mem),
	.load_done     (load_done),
	.load_error    (load_error),
	.machine_reset (machine_reset),
	.cheat_valid   (cheat_valid)
);

`default_nettype wire

//--- dv/tb_nes_loader.sv
////////////////////////////////////////////////////////////
// Testbench for the loader top level: clock, reset,
// file driven game, cheat and pad tests, watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_nes_loader
	import nes_loader_pkg::*;
();

	localparam int DL_RESET_CYCLES = 255;
	localparam int REC_WORDS = 20;  // kind, opt, 16 bytes, flags, error
	localparam int MAX_RECS = 32;
	localparam int SEL_BUSY = 0;
	localparam int SEL_DONE = 1;
	localparam int SEL_CHEAT = 2;
	localparam int SEL_RESET = 3;

	logic clk, reset_nes, dl_active, dl_wr, invert_mirroring, pad_strobe, swap_joys;
	logic [7:0] dl_index;
	logic [7:0] dl_data;
	logic [24:0] dl_addr;
	logic [1:0] pad_clock;
	logic [1:0] pad_data;
	pad_buttons_t joy_a, joy_b;
	mem_wr_t mem;
	mapper_flags_t mapper_flags;
	cheat_code_t cheat_code;
	logic load_busy, load_done, load_error, machine_reset, cheat_valid;

	logic [31:0] stim [MAX_RECS*REC_WORDS];
	logic [7:0]  exp_bytes [$];  // Payload still to appear on mem
	int          error_count = 0;
	int          wr_count = 0;
	int          prg_bytes = 0;
	int          exp_total = 0;
	int          cheat_pulses = 0;
	longint      limit_ns = 0;

	nes_loader_top #(.DL_RESET_CYCLES(DL_RESET_CYCLES)) u_nes_loader_top (
		.clk(clk), .reset_nes(reset_nes), .dl_active(dl_active), .dl_index(dl_index),
		.dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.invert_mirroring(invert_mirroring), .pad_strobe(pad_strobe),
		.pad_clock(pad_clock), .joy_a(joy_a), .joy_b(joy_b), .swap_joys(swap_joys),
		.mem(mem), .mapper_flags(mapper_flags), .load_busy(load_busy),
		.load_done(load_done), .load_error(load_error), .machine_reset(machine_reset),
		.cheat_code(cheat_code), .cheat_valid(cheat_valid), .pad_data(pad_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		$display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		error_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("Failure at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	// Testbench checks plus bound assertion failures
	function automatic int total_errors();
		return error_count + int'(u_nes_loader_top.u_nes_loader_assert.assert_fails);
	endfunction

	function automatic logic level_of(input int sel);
		case (sel)
			SEL_BUSY:  return load_busy;
			SEL_DONE:  return load_done;
			SEL_CHEAT: return cheat_valid;
			default:   return machine_reset;
		endcase
	endfunction

	function automatic logic [7:0] rec_byte(input int r, input int i);
		return stim[r*REC_WORDS + 2 + i][7:0];
	endfunction

	// Counts whole cycles until the signal reaches the level
	task automatic wait_level(input int sel, input logic level, input int limit,
			input string name, output int cycles);
		cycles = 0;
		@(negedge clk);
		while (level_of(sel) !== level && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (level_of(sel) !== level)
			report_failure($sformatf("%s did not reach %0b within %0d cycles", name, level, limit));
	endtask

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		@(posedge clk);
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
		@(posedge clk);
		dl_wr <= 1'b0;  // One idle cycle between strobes
	endtask

	////////////////////////////////////////////////////////////
	// Write monitor
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin : write_monitor
		logic [ADDR_W-1:0] exp_addr;
		logic [7:0]        exp_data;
		if (mem.write === 1'b1) begin
			exp_addr = (wr_count < prg_bytes) ? ADDR_W'(wr_count) :
				CHR_BASE + ADDR_W'(wr_count - prg_bytes);
			if (wr_count >= exp_total) begin
				report_failure("mem write beyond the page sizes of the header");
			end else begin
				exp_data = exp_bytes.pop_front();
				if (mem.addr !== exp_addr)
					report_mismatch("mem.addr", mem.addr, exp_addr);
				if (mem.data !== exp_data)
					report_mismatch("mem.data", mem.data, exp_data);
			end
			wr_count++;
		end
		if (cheat_valid === 1'b1)
			cheat_pulses++;
	end

	task automatic run_game(input int r);
		logic [7:0]    hdr [16];
		logic [7:0]    b;
		logic          exp_err;
		mapper_flags_t exp_flags;
		int            cycles;
		for (int i = 0; i < 16; i++)
			hdr[i] = rec_byte(r, i);
		exp_flags = stim[r*REC_WORDS + 18];
		exp_err   = stim[r*REC_WORDS + 19][0];
		prg_bytes = exp_err ? 0 : int'(hdr[4]) << 14;
		exp_total = exp_err ? 0 : prg_bytes + (int'(hdr[5]) << 13);
		wr_count  = 0;
		exp_bytes.delete();
		@(posedge clk);
		dl_index         <= 8'h00;
		dl_active        <= 1'b1;
		invert_mirroring <= stim[r*REC_WORDS + 1][0];
		for (int i = 0; i < 16; i++)
			send_byte(25'(i), hdr[i]);
		if (!exp_err) begin
			wait_level(SEL_BUSY, 1'b1, 10, "load_busy", cycles);
			if (cycles != 1)
				report_failure($sformatf("load_busy rose %0d cycles after the header", cycles));
			for (int i = 0; i < exp_total; i++) begin
				b = 8'($urandom);
				exp_bytes.push_back(b);
				send_byte(25'(16 + i), b);
			end
		end
		wait_level(SEL_DONE, 1'b1, 3, "load_done", cycles);
		if (load_error !== exp_err)
			report_mismatch("load_error", load_error, exp_err);
		if (wr_count != exp_total)
			report_mismatch("mem write count", wr_count, exp_total);
		if (machine_reset !== 1'b1)
			report_mismatch("machine_reset", machine_reset, 1'b1);
		if (mapper_flags !== '0)
			report_mismatch("mapper_flags", mapper_flags, 0);
		@(posedge clk);
		dl_active <= 1'b0;
		wait_level(SEL_RESET, 1'b0, DL_RESET_CYCLES + 20, "machine_reset", cycles);
		if (cycles < DL_RESET_CYCLES || cycles > DL_RESET_CYCLES + 5)
			report_failure($sformatf("machine_reset fell %0d cycles after the download", cycles));
		if (!exp_err && mapper_flags !== exp_flags)
			report_mismatch("mapper_flags", mapper_flags, exp_flags);
	endtask

	task automatic run_cheat(input int r);
		logic [7:0]  rec [16];
		cheat_code_t exp_code;
		int          cycles;
		for (int i = 0; i < 16; i++)
			rec[i] = rec_byte(r, i);
		// Little endian fields of four bytes each
		exp_code.flags   = {rec[3], rec[2], rec[1], rec[0]};
		exp_code.address = {rec[7], rec[6], rec[5], rec[4]};
		exp_code.compare = {rec[11], rec[10], rec[9], rec[8]};
		exp_code.replace = {rec[15], rec[14], rec[13], rec[12]};
		cheat_pulses = 0;
		wr_count     = 0;
		exp_total    = 0;
		@(posedge clk);
		dl_index  <= CHEAT_INDEX;
		dl_active <= 1'b1;
		for (int i = 0; i < 16; i++)
			send_byte(25'(i), rec[i]);
		wait_level(SEL_CHEAT, 1'b1, 5, "cheat_valid", cycles);
		@(posedge clk);
		dl_active <= 1'b0;
		repeat (2) @(negedge clk);
		if (cheat_code !== exp_code)
			report_mismatch("cheat_code", cheat_code, exp_code);
		if (cheat_pulses != 1)
			report_mismatch("cheat_valid pulses", cheat_pulses, 1);
		if (wr_count != 0)
			report_mismatch("mem write count", wr_count, 0);
	endtask

	task automatic run_pad(input int r);
		pad_buttons_t port0, port1;
		logic         swap;
		logic [1:0]   exp_bits;
		swap  = stim[r*REC_WORDS + 1][0];
		port0 = swap ? rec_byte(r, 1) : rec_byte(r, 0);
		port1 = swap ? rec_byte(r, 0) : rec_byte(r, 1);
		@(posedge clk);
		joy_a      <= rec_byte(r, 0);
		joy_b      <= rec_byte(r, 1);
		swap_joys  <= swap;
		pad_strobe <= 1'b1;
		@(posedge clk);
		pad_strobe <= 1'b0;
		@(negedge clk);
		for (int k = 0; k < 16; k++) begin
			exp_bits[0] = (k < 8) ? port0[7-k] : 1'b1;  // A first, ones after Right
			exp_bits[1] = (k < 8) ? port1[7-k] : 1'b1;
			if (pad_data !== exp_bits)
				report_mismatch($sformatf("pad_data bit %0d", k), pad_data, exp_bits);
			@(posedge clk);
			pad_clock <= 2'b11;
			@(posedge clk);
			pad_clock <= 2'b00;
			@(posedge clk);
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int     n_recs;
		int     failed;
		int     err_before;
		int     seed_state;
		longint bytes;
		string  kind_name;
		reset_nes = 1'b1;
		dl_active = 1'b0;
		dl_index = 8'h00;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = 8'h00;
		invert_mirroring = 1'b0;
		pad_strobe = 1'b0;
		pad_clock = 2'b00;
		joy_a = '0;
		joy_b = '0;
		swap_joys = 1'b0;
		seed_state = $urandom(91023);
		n_recs = 0;
		failed = 0;
		bytes = 0;
		for (int i = 0; i < MAX_RECS*REC_WORDS; i++)
			stim[i] = '1;  // Unused records read as end marker
		$readmemh("dv/nes_loader_input.txt", stim);
		while (n_recs < MAX_RECS && stim[n_recs*REC_WORDS] <= 2) begin
			if (stim[n_recs*REC_WORDS] == 0)
				bytes += 16 + (longint'(rec_byte(n_recs, 4)) << 14) +
					(longint'(rec_byte(n_recs, 5)) << 13);
			else if (stim[n_recs*REC_WORDS] == 1)
				bytes += 16;
			n_recs++;
		end
		limit_ns = 2 * bytes * 8 + 20000;
		repeat (3) @(posedge clk);
		reset_nes <= 1'b0;
		@(posedge clk);
		for (int r = 0; r < n_recs; r++) begin
			err_before = total_errors();
			case (stim[r*REC_WORDS])
				0: begin
					kind_name = "game";
					run_game(r);
				end
				1: begin
					kind_name = "cheat";
					run_cheat(r);
				end
				default: begin
					kind_name = "pad";
					run_pad(r);
				end
			endcase
			if (total_errors() != err_before)
				failed++;
			$display("Test %0d %s: %s", r, kind_name,
				(total_errors() == err_before) ? "ok" : "FAILED");
		end
		$display("Tests run %0d, tests failed %0d, errors %0d", n_recs, failed, total_errors());
		if (total_errors() == 0 && n_recs > 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Limit derived from the total byte count of the file
	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		$display("Watchdog expired after %0d ns, the tests did not finish", limit_ns);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- nes_loader.f
hdl/nes_loader_pkg.sv
hdl/ines_header_decode.sv
hdl/rom_load_fsm.sv
hdl/cheat_code_capture.sv
hdl/joypad_serializer.sv
hdl/nes_loader_top.sv
dv/nes_loader_assert.sv
dv/tb_nes_loader.sv

//--- Bender.yml
package:
  name: nes_loader

sources:
  - files:
      - hdl/nes_loader_pkg.sv
      - hdl/ines_header_decode.sv
      - hdl/rom_load_fsm.sv
      - hdl/cheat_code_capture.sv
      - hdl/joypad_serializer.sv
      - hdl/nes_loader_top.sv
  - target: test
    files:
      - dv/nes_loader_assert.sv
      - dv/tb_nes_loader.sv

//--- dv/nes_loader_input.txt
// kind opt b0..b15 exp_flags exp_error, kind 0 game (opt invert_mirroring), 1 cheat record,
// kind 2 pads (b0 joy_a, b1 joy_b, opt swap_joys); b0..b15 are header or cheat bytes
0 0 4E 45 53 1A 01 01 10 00 00 00 00 00 00 00 00 00 00000004 0
0 1 4E 45 53 1A 01 01 13 40 00 00 00 00 00 00 00 00 80000104 0
0 0 4E 45 53 1A 01 01 48 28 35 00 07 00 00 00 00 00 39AC0090 0
0 0 4E 45 53 1A 01 01 21 30 00 00 00 00 44 69 73 6B 00010008 0
0 0 4E 45 53 1A 01 00 00 00 00 00 00 00 00 00 00 00 00020000 0
0 0 4E 45 53 00 01 01 10 00 00 00 00 00 00 00 00 00 00000000 1
0 0 4E 45 53 1A 01 01 14 00 00 00 00 00 00 00 00 00 00000000 1
1 0 01 00 00 00 34 12 00 00 FF 00 00 00 EA 00 00 00 00000000 0
1 0 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00 00000000 0
2 0 A5 3C 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00000000 0
2 1 81 6E 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00000000 0
